/* filelist.f */
design/lb_pkg.sv
design/lb_if.sv
design/lb_host_bridge.sv
design/lb_delay.sv
design/lb_reg_bank.sv
design/lb_subsys_top.sv
verif/lb_clk_gen.sv
verif/tb_lb_subsys.sv

/* run_sim.sh */
#!/bin/sh
# build and run the localbus subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lb_subsys -Mdir obj_dir -o sim_lb \
  -f filelist.f > build.log 2>&1 \
  && ./obj_dir/sim_lb > sim.log 2>&1 \
  || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "^No errors$" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

/* verif/tb_lb_subsys.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_lb_subsys;

  localparam int DRIVE_DLY   = 2;   // inputs change this long after the rising edge
  localparam int TIMEOUT     = 100; // cycles allowed for any single wait
  localparam int RD_LAT_EDGE = 2 * lb_pkg::LB_NSTAGES + lb_pkg::RD_LATENCY + 2;
  localparam int WR_LAT_EDGE = 2;

  logic                     clk;
  logic                     rst;
  logic                     req;
  logic                     wr;
  logic [lb_pkg::LB_AW-1:0] addr;
  logic [lb_pkg::LB_DW-1:0] wdata;
  logic                     ack;
  logic [lb_pkg::LB_DW-1:0] rdata;

  logic [lb_pkg::LB_DW-1:0] model_regs [lb_pkg::REG_COUNT];
  logic [lb_pkg::LB_DW-1:0] pend_exp [$]; // expected read data, oldest first
  logic [lb_pkg::LB_DW-1:0] pend_got [$];
  logic [lb_pkg::LB_AW-1:0] pend_addr [$];
  logic [lb_pkg::LB_DW-1:0] exp_v;
  logic [lb_pkg::LB_DW-1:0] got_v;
  logic [lb_pkg::LB_AW-1:0] adr_v;
  int                       errors;
  int                       checks;
  bit                       aborted; // set once a handshake times out

  lb_clk_gen #(.PERIOD(20)) u_clk (.clk(clk));

  lb_subsys_top UUT (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .wr    (wr),
    .addr  (addr),
    .wdata (wdata),
    .ack   (ack),
    .rdata (rdata)
  );

  // what a read of this address should return given everything written so far
  function automatic logic [lb_pkg::LB_DW-1:0] expected_read(input logic [lb_pkg::LB_AW-1:0] a);
    if (a < lb_pkg::REG_COUNT) begin
      return model_regs[int'(a)];
    end
    return '0;
  endfunction

  task automatic model_write(input logic [lb_pkg::LB_AW-1:0] a, input logic [lb_pkg::LB_DW-1:0] d);
    if (a < lb_pkg::REG_COUNT) begin
      model_regs[int'(a)] = d; // unmapped writes are dropped
    end
  endtask

  // one four-phase access, entered and left DRIVE_DLY after a rising edge
  task automatic bus_access(input logic is_wr, input logic [lb_pkg::LB_AW-1:0] a,
                            input logic [lb_pkg::LB_DW-1:0] d);
    int edges;
    int exp_lat;
    bit seen;
    if (aborted) return;
    exp_lat = is_wr ? WR_LAT_EDGE : RD_LAT_EDGE;
    wr    = is_wr;
    addr  = a;
    wdata = d;
    req   = 1'b1;
    edges = -1; // the first edge below is the one that samples req
    seen  = 1'b0;
    while (!seen && edges < TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DLY;
      edges++;
      seen = ack;
    end
    if (!seen) begin
      $display("Timeout: ack never came up for the access to address 0x%0h", a);
      errors++;
      aborted = 1'b1;
      req = 1'b0;
      return;
    end
    checks++;
    assert (edges == exp_lat) else begin
      errors++;
      $display("Fail at %0t: ack rose %0d edges after req, expected %0d", $time, edges, exp_lat);
    end
    if (is_wr) begin
      model_write(a, d);
    end else begin
      pend_exp.push_back(expected_read(a));
      pend_got.push_back(rdata);
      pend_addr.push_back(a);
    end
    req   = 1'b0;
    edges = 0;
    seen  = 1'b1;
    while (seen && edges < TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DLY;
      edges++;
      seen = ack;
    end
    if (seen) begin
      $display("Timeout: ack stayed high after req was released");
      errors++;
      aborted = 1'b1;
      return;
    end
    checks++;
    assert (edges == 1) else begin
      errors++;
      $display("Fail at %0t: ack fell %0d edges after req dropped, expected 1", $time, edges);
    end
  endtask

  // comparison of captured read data against the model
  initial begin
    forever begin
      @(posedge clk);
      while (pend_exp.size() > 0) begin
        exp_v = pend_exp.pop_front();
        got_v = pend_got.pop_front();
        adr_v = pend_addr.pop_front();
        checks++;
        assert (got_v === exp_v) else begin
          errors++;
          $display("Fail at %0t: read of 0x%0h returned 0x%08h, expected 0x%08h",
                   $time, adr_v, got_v, exp_v);
        end
      end
    end
  end

  initial begin
    int order [lb_pkg::REG_COUNT];
    logic [lb_pkg::LB_AW-1:0] unmapped [$];
    logic [lb_pkg::LB_AW-1:0] a;
    logic [lb_pkg::LB_DW-1:0] d;
    int j;
    int tmp;
    int n;
    rst = 1'b1;
    req = 1'b0;
    wr = 1'b0;
    addr = '0;
    wdata = '0;
    errors = 0;
    checks = 0;
    aborted = 1'b0;
    void'($urandom(32'h2fd26b73));
    for (int i = 0; i < lb_pkg::REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;
    checks++;
    assert (ack === 1'b0) else begin
      errors++;
      $display("Fail at %0t: ack is high right after reset", $time);
    end
    for (int i = 0; i < lb_pkg::REG_COUNT; i++) begin
      bus_access(1'b0, lb_pkg::LB_AW'(i), '0); // every register starts at zero
    end
    for (int i = 0; i < lb_pkg::REG_COUNT; i++) begin
      bus_access(1'b1, lb_pkg::LB_AW'(i), $urandom);
    end
    repeat (8) begin
      bus_access(1'b1, lb_pkg::LB_AW'($urandom % lb_pkg::REG_COUNT), $urandom);
    end
    for (int i = 0; i < lb_pkg::REG_COUNT; i++) begin
      order[i] = i;
    end
    for (int i = lb_pkg::REG_COUNT - 1; i > 0; i--) begin
      j = $urandom % (i + 1);
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < lb_pkg::REG_COUNT; i++) begin
      bus_access(1'b0, lb_pkg::LB_AW'(order[i]), '0);
    end
    // addresses past the bank, some of them aliasing mapped registers in the low bits
    unmapped.push_back(lb_pkg::LB_AW'(lb_pkg::REG_COUNT));
    unmapped.push_back(lb_pkg::LB_AW'(lb_pkg::REG_COUNT + 3));
    unmapped.push_back('1);
    repeat (5) begin
      a = lb_pkg::LB_AW'(lb_pkg::REG_COUNT
                         + ($urandom % ((1 << lb_pkg::LB_AW) - lb_pkg::REG_COUNT)));
      unmapped.push_back(a);
    end
    foreach (unmapped[k]) begin
      bus_access(1'b1, unmapped[k], $urandom);
    end
    for (int i = 0; i < lb_pkg::REG_COUNT; i++) begin
      bus_access(1'b0, lb_pkg::LB_AW'(i), '0);
    end
    foreach (unmapped[k]) begin
      bus_access(1'b0, unmapped[k], '0);
    end
    repeat (6) begin
      a = lb_pkg::LB_AW'($urandom % lb_pkg::REG_COUNT);
      d = $urandom;
      bus_access(1'b1, a, d);
      bus_access(1'b0, a, '0); // issued the moment ack is low again
    end
    n = 0;
    while (pend_exp.size() > 0 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (pend_exp.size() > 0) begin
      errors++;
      $display("Read results were still waiting to be compared at the end of the run");
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/lb_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

// free-running testbench clock, starts low
module lb_clk_gen #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #(PERIOD / 2) clk = ~clk; // half period per phase
  end

endmodule

`default_nettype wire

/* design/lb_subsys_top.sv */
`timescale 1ns/1ns
`default_nettype none

module lb_subsys_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req,
  input  logic                     wr,
  input  logic [lb_pkg::LB_AW-1:0] addr,
  input  logic [lb_pkg::LB_DW-1:0] wdata,
  output logic                     ack,
  output logic [lb_pkg::LB_DW-1:0] rdata
);

  lb_if host_bus ();   // bridge to pipeline
  lb_if periph_bus (); // pipeline to register bank

  // the bridge waits out the pipeline both ways plus the bank's read latency
  lb_host_bridge #(
    .RD_WAIT(2 * lb_pkg::LB_NSTAGES + lb_pkg::RD_LATENCY)
  ) u_bridge (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .wr    (wr),
    .addr  (addr),
    .wdata (wdata),
    .ack   (ack),
    .rdata (rdata),
    .bus   (host_bus)
  );

  lb_delay #(
    .NSTAGES(lb_pkg::LB_NSTAGES)
  ) u_delay (
    .clk (clk),
    .rst (rst),
    .h   (host_bus),
    .p   (periph_bus)
  );

  lb_reg_bank u_bank (
    .clk (clk),
    .rst (rst),
    .bus (periph_bus)
  );

endmodule

`default_nettype wire

/* design/lb_reg_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module lb_reg_bank (
  input  logic clk,
  input  logic rst,
  lb_if.periph bus
);

  localparam int IW = (lb_pkg::REG_COUNT > 1) ? $clog2(lb_pkg::REG_COUNT) : 1;
  localparam int RL = lb_pkg::RD_LATENCY;

  logic [lb_pkg::LB_DW-1:0] regs    [lb_pkg::REG_COUNT];
  logic [lb_pkg::LB_DW-1:0] rd_pipe [RL];
  logic [IW-1:0]            idx;
  logic                     mapped;

  // only the low bits select a register, the rest just decide whether it exists
  assign idx    = bus.addr[IW-1:0];
  assign mapped = bus.addr < lb_pkg::LB_AW'(lb_pkg::REG_COUNT);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < lb_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (bus.wstb && bus.wen && mapped) begin
      regs[idx] <= bus.wdata;
    end
  end

  // first stage updates only on a read, so rdata holds between reads
  always_ff @(posedge clk) begin
    if (bus.rstb) begin
      rd_pipe[0] <= mapped ? regs[idx] : '0; // unmapped reads come back as zero
    end
    for (int i = 1; i < RL; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign bus.rdata = rd_pipe[RL-1];

  a_wen_with_wstb : assert property (@(posedge clk) disable iff (rst)
    bus.wen |-> bus.wstb);

endmodule

`default_nettype wire

/* design/lb_delay.sv */
`timescale 1ns/1ns
`default_nettype none

// NSTAGES of extra registering between a localbus host and its peripheral
module lb_delay #(
  parameter int NSTAGES = lb_pkg::LB_NSTAGES
) (
  input  logic clk,
  input  logic rst,
  lb_if.periph h, // toward the host
  lb_if.host   p  // toward the peripheral
);

  generate
    if (NSTAGES == 0) begin : g_passthrough
      assign p.wen   = h.wen;
      assign p.addr  = h.addr;
      assign p.wdata = h.wdata;
      assign p.wstb  = h.wstb;
      assign p.rstb  = h.rstb;
      assign h.rdata = p.rdata;
    end else begin : g_pipeline
      logic [NSTAGES-1:0]        wen_q;
      logic [NSTAGES-1:0]        wstb_q;
      logic [NSTAGES-1:0]        rstb_q;
      logic [lb_pkg::LB_AW-1:0]  addr_q  [NSTAGES];
      logic [lb_pkg::LB_DW-1:0]  wdata_q [NSTAGES];
      logic [lb_pkg::LB_DW-1:0]  rdata_q [NSTAGES]; // return path, peripheral to host

      // control bits get cleared so no phantom strobe leaves after reset
      always_ff @(posedge clk) begin
        if (rst) begin
          wen_q  <= '0;
          wstb_q <= '0;
          rstb_q <= '0;
        end else begin
          wen_q[0]  <= h.wen;
          wstb_q[0] <= h.wstb;
          rstb_q[0] <= h.rstb;
          for (int i = 1; i < NSTAGES; i++) begin
            wen_q[i]  <= wen_q[i-1];
            wstb_q[i] <= wstb_q[i-1];
            rstb_q[i] <= rstb_q[i-1];
          end
        end
      end

      always_ff @(posedge clk) begin
        addr_q[0]  <= h.addr;
        wdata_q[0] <= h.wdata;
        rdata_q[0] <= p.rdata;
        for (int i = 1; i < NSTAGES; i++) begin
          addr_q[i]  <= addr_q[i-1];
          wdata_q[i] <= wdata_q[i-1];
          rdata_q[i] <= rdata_q[i-1];
        end
      end

      assign p.wen   = wen_q[NSTAGES-1];
      assign p.wstb  = wstb_q[NSTAGES-1];
      assign p.rstb  = rstb_q[NSTAGES-1];
      assign p.addr  = addr_q[NSTAGES-1];
      assign p.wdata = wdata_q[NSTAGES-1];
      assign h.rdata = rdata_q[NSTAGES-1];

      a_wstb_delay : assert property (@(posedge clk) disable iff (rst)
        h.wstb |-> ##NSTAGES p.wstb);
      a_rstb_delay : assert property (@(posedge clk) disable iff (rst)
        h.rstb |-> ##NSTAGES p.rstb);
    end
  endgenerate

endmodule

`default_nettype wire

/* design/lb_host_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module lb_host_bridge #(
  parameter int RD_WAIT = 2 * lb_pkg::LB_NSTAGES + lb_pkg::RD_LATENCY
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req,
  input  logic                     wr,
  input  logic [lb_pkg::LB_AW-1:0] addr,
  input  logic [lb_pkg::LB_DW-1:0] wdata,
  output logic                     ack,
  output logic [lb_pkg::LB_DW-1:0] rdata,
  lb_if.host                       bus
);

  localparam int CW = (RD_WAIT > 1) ? $clog2(RD_WAIT) : 1;

  typedef enum logic [2:0] {
    st_idle,
    st_strobe,
    st_wait,
    st_ack,
    st_release
  } state_t;

  state_t        state;
  logic [CW-1:0] wait_cnt; // counts down the read round trip

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      ack      <= 1'b0;
      bus.wen  <= 1'b0;
      bus.wstb <= 1'b0;
      bus.rstb <= 1'b0;
      wait_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req) begin
            bus.wen  <= wr;
            bus.wstb <= wr;
            bus.rstb <= !wr;
            state    <= st_strobe;
          end
        end
        st_strobe: begin
          // strobe is only ever one cycle wide
          bus.wen  <= 1'b0;
          bus.wstb <= 1'b0;
          bus.rstb <= 1'b0;
          if (bus.rstb) begin
            wait_cnt <= CW'(RD_WAIT - 1);
            state    <= st_wait;
          end else begin
            state <= st_ack; // writes are posted, no need to wait for the bank
          end
        end
        st_wait: begin
          if (wait_cnt == '0) begin
            state <= st_ack;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        st_ack: begin
          ack   <= 1'b1;
          state <= st_release;
        end
        st_release: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // address and write data are launched with the strobe and then simply held
  always_ff @(posedge clk) begin
    if (state == st_idle && req) begin
      bus.addr  <= addr;
      bus.wdata <= wdata;
    end
  end

  // the last wait cycle is the one where returned data has settled on the bus
  always_ff @(posedge clk) begin
    if (state == st_wait && wait_cnt == '0) begin
      rdata <= bus.rdata;
    end
  end

  a_strobe_excl : assert property (@(posedge clk) disable iff (rst)
    !(bus.wstb && bus.rstb));

  // ack may only come up for a request that was still being held
  a_ack_needs_req : assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> $past(req));

endmodule

`default_nettype wire

/* design/lb_if.sv */
`timescale 1ns/1ns
`default_nettype none

// one localbus segment: forward strobe cycle plus the read return
interface lb_if;

  logic                     wen;   // high together with wstb on a write
  logic [lb_pkg::LB_AW-1:0] addr;
  logic [lb_pkg::LB_DW-1:0] wdata;
  logic                     wstb;  // single-cycle write strobe
  logic                     rstb;  // single-cycle read strobe
  logic [lb_pkg::LB_DW-1:0] rdata; // returned by the peripheral side

  // the side that issues strobes
  modport host (
    output wen, addr, wdata, wstb, rstb,
    input  rdata
  );

  // the side that answers them
  modport periph (
    input  wen, addr, wdata, wstb, rstb,
    output rdata
  );

endinterface

`default_nettype wire

/* design/lb_pkg.sv */
`default_nettype none

package lb_pkg;

  // localbus widths
  localparam int LB_DW = 32;
  localparam int LB_AW = 21;

  // routing pipeline depth between bridge and peripheral
  localparam int LB_NSTAGES = 2;

  // number of implemented registers in the bank
  localparam int REG_COUNT = 16;

  // cycles from rstb at the bank to valid rdata at its output
  localparam int RD_LATENCY = 1;

endpackage

`default_nettype wire
